//--- memPkg.sv
package memPkg;

    localparam int dataWidth       = 32;
    localparam int sbEntries       = 4;
    localparam int sbIndexWidth    = 2;
    localparam int sbDrainEntry    = sbEntries - 1;    // only the last entry drains.
    localparam int cacheLines      = 16;
    localparam int cacheIndexWidth = 4;
    localparam int memWords        = 256;
    localparam int memAddrWidth    = 8;
    localparam int memLatency      = 3;
    localparam int lanes           = dataWidth / 8;
    localparam int tagWidth        = dataWidth - cacheIndexWidth - 2;
    localparam int latCountWidth   = $clog2(memLatency + 1);

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [lanes-1:0]     byteMask_t;
    typedef logic [tagWidth-1:0]  cacheTag_t;

    typedef enum logic [1:0] {
        stIdle,
        stFill,
        stWrite
    } cacheState_t;

    // one lane for a byte access, all lanes for a word.
    function automatic byteMask_t laneMask(input logic byteOp, input logic [1:0] offset);
        return byteOp ? (byteMask_t'(1) << offset) : '1;
    endfunction

    function automatic word_t mergeLanes(input word_t oldWord, input word_t newWord,
                                         input byteMask_t mask);
        word_t merged;
        merged = oldWord;
        for (int lane = 0; lane < lanes; lane++) begin
            if (mask[lane]) begin
                merged[8*lane +: 8] = newWord[8*lane +: 8];    // new lane wins.
            end
        end
        return merged;
    endfunction

endpackage

//--- mainMemory.sv
`timescale 1ns/1ps

module mainMemory
    import memPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic [memAddrWidth-1:0] memAddr,
    input  word_t                   memWriteData,
    input  byteMask_t               memMask,
    output word_t                   memReadData,
    output logic                    memDone
);

    word_t                    memArray [memWords];
    logic                     busy;
    logic                     request;
    logic                     expire;
    logic [latCountWidth-1:0] count;

    assign request = memRead | memWrite;
    assign expire  = busy && (count == latCountWidth'(1));

    // the requester leaves its state with memDone, so the level seen
    // during the pulse still belongs to the old request.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            count   <= '0;
            memDone <= 1'b0;
            for (int i = 0; i < memWords; i++) begin
                memArray[i] <= '0;
            end
        end else begin
            memDone <= 1'b0;
            if (!busy) begin
                if (request && !memDone) begin
                    busy  <= 1'b1;
                    count <= latCountWidth'(memLatency - 1);
                end
            end else if (expire) begin
                busy    <= 1'b0;
                memDone <= 1'b1;
                if (memWrite) begin
                    memArray[memAddr] <= mergeLanes(memArray[memAddr], memWriteData, memMask);
                end
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (expire && memRead) begin
            memReadData <= memArray[memAddr];    // valid with memDone.
        end
    end

endmodule

//--- dataCache.sv
`timescale 1ns/1ps

module dataCache
    import memPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cacheRead,
    input  logic                    cacheWrite,
    input  word_t                   reqAddr,
    input  word_t                   writeData,
    input  byteMask_t               writeMask,
    output word_t                   readData,
    output logic                    cacheReady,
    output logic                    memRead,
    output logic                    memWrite,
    output logic [memAddrWidth-1:0] memAddr,
    output word_t                   memWriteData,
    output byteMask_t               memMask,
    input  word_t                   memReadData,
    input  logic                    memDone
);

    cacheTag_t                  tagArray  [cacheLines];
    word_t                      dataArray [cacheLines];
    logic [cacheLines-1:0]      lineValid;

    cacheState_t                state;
    cacheState_t                nextState;
    logic [cacheIndexWidth-1:0] index;
    cacheTag_t                  reqTag;
    logic                       tagHit;
    logic                       fillDone;
    logic                       writeDone;

    assign index  = reqAddr[cacheIndexWidth+1:2];
    assign reqTag = reqAddr[dataWidth-1:cacheIndexWidth+2];
    assign tagHit = lineValid[index] && (tagArray[index] == reqTag);

    assign memAddr      = reqAddr[memAddrWidth+1:2];
    assign memWriteData = writeData;
    assign memMask      = writeMask;

    // the read needs a tag check first; a write goes straight through.
    assign memRead  = (state == stFill);
    assign memWrite = (state == stWrite) || (state == stIdle && cacheWrite);

    assign fillDone  = (state == stFill) && memDone;
    assign writeDone = (state == stWrite) && memDone;

    always_comb begin
        nextState  = state;
        cacheReady = 1'b0;
        readData   = dataArray[index];
        case (state)
            stIdle: begin
                if (cacheWrite) begin
                    nextState = stWrite;
                end else if (cacheRead) begin
                    if (tagHit) begin
                        cacheReady = 1'b1;    // hit answers at once.
                    end else begin
                        nextState = stFill;
                    end
                end
            end
            stFill: begin
                if (memDone) begin
                    readData   = memReadData;    // bypass the line being filled.
                    cacheReady = 1'b1;
                    nextState  = stIdle;
                end
            end
            stWrite: begin
                if (memDone) begin
                    cacheReady = 1'b1;
                    nextState  = stIdle;
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            lineValid <= '0;
        end else begin
            state <= nextState;
            if (fillDone) begin
                lineValid[index] <= 1'b1;
            end
        end
    end

    // a write only touches a line it already owns.
    always_ff @(posedge clk) begin
        if (fillDone) begin
            tagArray[index]  <= reqTag;
            dataArray[index] <= memReadData;
        end else if (writeDone && tagHit) begin
            dataArray[index] <= mergeLanes(dataArray[index], writeData, writeMask);
        end
    end

endmodule

//--- storeBuffer.sv
`timescale 1ns/1ps

module storeBuffer
    import memPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      writeOp,
    input  logic      readOp,
    input  logic      byteOp,
    input  word_t     addr,
    input  word_t     storeData,
    input  word_t     cacheReadData,
    input  logic      cacheReady,
    output word_t     loadData,
    output logic      loadValid,
    output logic      stall,
    output logic      cacheRead,
    output logic      cacheWrite,
    output word_t     reqAddr,
    output word_t     drainAddr,
    output word_t     drainData,
    output byteMask_t drainMask
);

    word_t                   entryAddr [sbEntries];
    word_t                   entryData [sbEntries];
    byteMask_t               entryMask [sbEntries];
    logic [sbEntries-1:0]    entryValid;

    logic                    storeReq;
    logic                    loadReq;
    logic                    full;
    logic                    hit;
    logic                    covered;
    logic                    drainBusy;
    logic                    storeStall;
    logic                    loadStall;
    logic [sbIndexWidth-1:0] hitIdx;
    logic [sbIndexWidth-1:0] freeIdx;
    logic [sbIndexWidth-1:0] targetIdx;
    byteMask_t               reqMask;
    byteMask_t               hitMask;
    word_t                   storeLanes;
    word_t                   forwardWord;

    assign storeReq   = enable & writeOp;
    assign loadReq    = enable & readOp;
    assign reqMask    = laneMask(byteOp, addr[1:0]);
    assign storeLanes = byteOp ? {lanes{storeData[7:0]}} : storeData;    // mask picks the lane.
    assign full       = &entryValid;

    // lowest valid entry holding the same word.
    always_comb begin
        hit    = 1'b0;
        hitIdx = '0;
        for (int i = sbEntries - 1; i >= 0; i--) begin
            if (entryValid[i] && entryAddr[i][dataWidth-1:2] == addr[dataWidth-1:2]) begin
                hit    = 1'b1;
                hitIdx = sbIndexWidth'(i);
            end
        end
    end

    always_comb begin
        freeIdx = '0;
        for (int i = sbEntries - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                freeIdx = sbIndexWidth'(i);
            end
        end
    end

    assign hitMask   = hit ? entryMask[hitIdx] : '0;
    assign covered   = hit && ((hitMask & reqMask) == reqMask);
    assign targetIdx = hit ? hitIdx : freeIdx;

    // buffered lanes over the cache word.
    assign forwardWord = mergeLanes(cacheReadData, entryData[hitIdx], hitMask);
    assign loadData    = byteOp ? {{(dataWidth-8){1'b0}}, forwardWord[8*addr[1:0] +: 8]}
                                : forwardWord;

    // a drain once started holds until the cache finishes it.
    assign cacheWrite = full & (drainBusy | ~loadReq);
    assign cacheRead  = loadReq & ~covered & ~drainBusy;
    assign loadValid  = loadReq & ~drainBusy & (covered | cacheReady);

    assign drainAddr = entryAddr[sbDrainEntry];
    assign drainData = entryData[sbDrainEntry];
    assign drainMask = entryMask[sbDrainEntry];
    assign reqAddr   = cacheWrite ? drainAddr : addr;

    // a hit on the draining entry waits too, or its merge would be lost.
    assign storeStall = storeReq & full & (~hit | (hitIdx == sbIndexWidth'(sbDrainEntry)));
    assign loadStall  = loadReq & (drainBusy | (~covered & ~cacheReady));
    assign stall      = storeStall | loadStall;

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            drainBusy  <= 1'b0;
        end else begin
            drainBusy <= cacheWrite & ~cacheReady;
            if (cacheWrite && cacheReady) begin
                entryValid[sbDrainEntry] <= 1'b0;    // written through to memory.
            end
            if (storeReq && !stall && !hit) begin
                entryValid[freeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (storeReq && !stall) begin
            entryAddr[targetIdx] <= {addr[dataWidth-1:2], 2'b00};
            entryData[targetIdx] <= mergeLanes(entryData[targetIdx], storeLanes, reqMask);
            entryMask[targetIdx] <= hitMask | reqMask;
        end
    end

endmodule

//--- memStage.sv
`timescale 1ns/1ps

module memStage
    import memPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  enable,
    input  logic  writeOp,
    input  logic  readOp,
    input  logic  byteOp,
    input  word_t addr,
    input  word_t storeData,
    output word_t loadData,
    output logic  loadValid,
    output logic  stall
);

    logic                    cacheRead;
    logic                    cacheWrite;
    logic                    cacheReady;
    word_t                   cacheReadData;
    word_t                   reqAddr;
    word_t                   drainAddr;
    word_t                   drainData;
    byteMask_t               drainMask;

    logic                    memRead;
    logic                    memWrite;
    logic [memAddrWidth-1:0] memAddr;
    word_t                   memWriteData;
    byteMask_t               memMask;
    word_t                   memReadData;
    logic                    memDone;

    storeBuffer i_storeBuffer (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .writeOp       (writeOp),
        .readOp        (readOp),
        .byteOp        (byteOp),
        .addr          (addr),
        .storeData     (storeData),
        .cacheReadData (cacheReadData),
        .cacheReady    (cacheReady),
        .loadData      (loadData),
        .loadValid     (loadValid),
        .stall         (stall),
        .cacheRead     (cacheRead),
        .cacheWrite    (cacheWrite),
        .reqAddr       (reqAddr),
        .drainAddr     (drainAddr),
        .drainData     (drainData),
        .drainMask     (drainMask)
    );

    dataCache i_dataCache (
        .clk          (clk),
        .rst          (rst),
        .cacheRead    (cacheRead),
        .cacheWrite   (cacheWrite),
        .reqAddr      (reqAddr),
        .writeData    (drainData),
        .writeMask    (drainMask),
        .readData     (cacheReadData),
        .cacheReady   (cacheReady),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memMask      (memMask),
        .memReadData  (memReadData),
        .memDone      (memDone)
    );

    mainMemory i_mainMemory (
        .clk          (clk),
        .rst          (rst),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memMask      (memMask),
        .memReadData  (memReadData),
        .memDone      (memDone)
    );

endmodule

//--- memStageTb.sv
`timescale 1ns/1ps

module memStageTb
    import memPkg::*;
();

    localparam int requestBudget = 80;    // directed requests plus the random mix.
    localparam int timeoutCycles = requestBudget * (memLatency + 2) * 5;
    localparam int randomOps     = 50;

    logic        clk;
    logic        rst;
    logic        enable;
    logic        writeOp;
    logic        readOp;
    logic        byteOp;
    word_t       addr;
    word_t       storeData;
    word_t       loadData;
    logic        loadValid;
    logic        stall;

    word_t       model [memWords];
    word_t       expected;
    word_t       randAddr;
    word_t       randWord;
    logic [31:0] ctrl;
    int          cycleCount = 0;
    int          waits;
    integer      seed;

    memStage i_dut (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .writeOp   (writeOp),
        .readOp    (readOp),
        .byteOp    (byteOp),
        .addr      (addr),
        .storeData (storeData),
        .loadData  (loadData),
        .loadValid (loadValid),
        .stall     (stall)
    );

    always #50 clk = ~clk;

    task automatic abortRun();
        $display("Checks failed");
        $fatal(1);
    endtask

    // what a load must return, byte loads zero-extended.
    function automatic word_t expectedLoad(input word_t a, input logic isByte);
        word_t w;
        w = model[a[memAddrWidth+1:2]];
        if (isByte) begin
            return {24'h0, w[8*a[1:0] +: 8]};
        end
        return w;
    endfunction

    task automatic applyStore(input word_t a, input word_t d, input logic isByte);
        if (isByte) begin
            model[a[memAddrWidth+1:2]][8*a[1:0] +: 8] = d[7:0];    // lane from the low bits.
        end else begin
            model[a[memAddrWidth+1:2]] = d;
        end
    endtask

    // compare at each edge, before the DUT state moves.
    always @(posedge clk) begin
        if (!rst) begin
            assert (!$isunknown({stall, loadValid})) else begin
                $display("stall or loadValid went unknown after reset");
                abortRun();
            end
            if (!enable) begin
                assert (!stall && !loadValid) else begin
                    $display("[FAIL] stall/loadValid while idle: expected %h/%h, actual %h/%h",
                             1'b0, 1'b0, stall, loadValid);
                    abortRun();
                end
            end
            if (loadValid) begin
                assert (!stall) else begin
                    $display("[FAIL] stall with loadValid: expected %h, actual %h", 1'b0, stall);
                    abortRun();
                end
            end
            if (enable && readOp && !stall) begin
                expected = expectedLoad(addr, byteOp);
                assert (loadValid) else begin
                    $display("[FAIL] loadValid for load at %h: expected %h, actual %h",
                             addr, 1'b1, loadValid);
                    abortRun();
                end
                assert (loadData === expected) else begin
                    $display("[FAIL] loadData at %h: expected %h, actual %h",
                             addr, expected, loadData);
                    abortRun();
                end
            end
            if (enable && writeOp && !stall) begin
                applyStore(addr, storeData, byteOp);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            abortRun();
        end
    end

    // holds the request until an edge sees stall low.
    task automatic request(input logic isWrite, input logic isByte, input word_t a,
                           input word_t d, output int stallCycles);
        enable      = 1'b1;
        writeOp     = isWrite;
        readOp      = !isWrite;
        byteOp      = isByte;
        addr        = a;
        storeData   = d;
        stallCycles = 0;
        @(posedge clk);
        while (stall) begin
            stallCycles++;
            @(posedge clk);
        end
        #1;
        enable  = 1'b0;
        writeOp = 1'b0;
        readOp  = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic expectNoStall(input string what);
        assert (waits == 0) else begin
            $display("[FAIL] stall cycles for %s: expected %h, actual %h", what, 0, waits);
            abortRun();
        end
    endtask

    task automatic expectStall(input string what);
        assert (waits > 0) else begin
            $display("%s was accepted without any stall", what);
            abortRun();
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        enable    = 1'b0;
        writeOp   = 1'b0;
        readOp    = 1'b0;
        byteOp    = 1'b0;
        addr      = '0;
        storeData = '0;
        seed      = 32'ha0fc;
        for (int i = 0; i < memWords; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        idle(1);

        request(0, 0, 32'h0000_0004, '0, waits);    // memory reads zero after reset.
        request(0, 1, 32'h0000_0083, '0, waits);

        request(1, 0, 32'h0000_0010, 32'h1234_5678, waits);
        expectNoStall("word store");
        request(0, 0, 32'h0000_0010, '0, waits);
        expectNoStall("forwarded load");

        request(1, 0, 32'h0000_0010, 32'hcafe_0001, waits);
        request(1, 0, 32'h0000_0010, 32'hcafe_0002, waits);
        request(0, 0, 32'h0000_0010, '0, waits);
        expectNoStall("load after merged stores");
        for (int i = 2; i <= 4; i++) begin
            request(1, 0, word_t'(i * 16), 32'h5a00_0000 + i, waits);
            expectNoStall("store into a free entry");
        end

        request(1, 0, 32'h0000_0050, 32'h0bad_f00d, waits);
        expectStall("store to a full buffer");

        // word 0x40 now sits in memory only, and its cache line holds another tag.
        request(1, 1, 32'h0000_0042, 32'h0000_00a5, waits);
        request(0, 0, 32'h0000_0040, '0, waits);
        expectStall("partly buffered load");
        for (int lane = 0; lane < 4; lane++) begin
            request(0, 1, word_t'(32'h40 + lane), '0, waits);
            expectNoStall("byte load after the fill");
        end
        for (int i = 1; i <= 5; i++) begin
            request(0, 0, word_t'(i * 16), '0, waits);
        end

        // words 0-7 and 16-23 share cache lines, so tags conflict.
        for (int n = 0; n < randomOps; n++) begin
            ctrl     = $random(seed);
            randWord = $random(seed);
            randAddr = {25'h0, ctrl[7], 1'b0, ctrl[6:4], ctrl[1] ? ctrl[3:2] : 2'b00};
            request(ctrl[0], ctrl[1], randAddr, randWord, waits);
            if (ctrl[9:8] == 2'b00) begin
                idle(memLatency + 1);
            end
        end

        idle(memLatency + 2);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- sim.f
memPkg.sv
mainMemory.sv
dataCache.sv
storeBuffer.sv
memStage.sv
memStageTb.sv
